// File: apb_addr_decode.sv
// apb_addr_decode
// Matches the request address against the peripheral windows and raises
// the select of one block, or flags a miss when nothing matches.

`timescale 1ns/1ps

module apb_addr_decode (
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::addr_t  paddr,
    input  apb_pkg::data_t  pwdata,
    apb_if.requester        slv [apb_pkg::NB_SLAVE],
    output logic            miss
);

    // one bit per window that contains the current address
    logic [apb_pkg::NB_SLAVE-1:0] hit;

    always_comb begin
        for (int i = 0; i < apb_pkg::NB_SLAVE; i++) begin
            hit[i] = (paddr >= periph_map_pkg::window_start[i]) &&
                     (paddr <= periph_map_pkg::window_end[i]);
        end
    end

    // windows do not overlap, so at most one hit bit is set
    assign miss = psel && (hit == '0);

    genvar g;
    generate
        for (g = 0; g < apb_pkg::NB_SLAVE; g++) begin : g_fwd
            // only the matching block sees its select go high
            assign slv[g].psel    = psel && hit[g];

            // penable and the payload are shared by all blocks, as on a
            // normal APB segment
            assign slv[g].penable = penable;
            assign slv[g].pwrite  = pwrite;
            assign slv[g].paddr   = paddr;
            assign slv[g].pwdata  = pwdata;
        end
    endgenerate

endmodule

// File: apb_if.sv
// apb_if
// APB signal bundle between the decoder, the register blocks and the
// response multiplexer.

`timescale 1ns/1ps

interface apb_if;

    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_pkg::addr_t paddr;
    apb_pkg::data_t pwdata;
    apb_pkg::data_t prdata;
    logic           pready;
    logic           pslverr;

    // side that starts transfers
    modport requester (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    // side that completes transfers
    modport completer (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

    // passive view of the whole bus
    modport monitor (
        input psel, penable, pwrite, paddr, pwdata, prdata, pready, pslverr
    );

endinterface

// File: apb_pkg.sv
// apb_pkg
// APB bus widths, transfer field types and the register block geometry
// shared by the peripheral bus and its register blocks.

package apb_pkg;

    // bus widths
    localparam int unsigned ADDR_WIDTH = 32;
    localparam int unsigned DATA_WIDTH = 32;

    // number of peripheral register blocks behind the decoder
    localparam int unsigned NB_SLAVE = 4;

    // each block holds this many 32-bit words, word 0 is the identification word
    localparam int unsigned REGS_PER_SLAVE = 4;

    // width of the word index inside one block
    localparam int unsigned REG_IDX_WIDTH = $clog2(REGS_PER_SLAVE);

    // APB transfer fields
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;

endpackage

// File: apb_reg_slave.sv
// apb_reg_slave
// One peripheral register block: a read-only identification word followed
// by three read/write words, completing every transfer without wait states.

`timescale 1ns/1ps

module apb_reg_slave #(
    parameter int unsigned SLAVE_INDEX = 0
) (
    input  logic       clk_i,
    input  logic       arst_n,
    apb_if.completer   bus
);

    localparam apb_pkg::data_t ID_WORD =
        periph_map_pkg::ID_BASE + apb_pkg::data_t'(SLAVE_INDEX);

    // words 1 and up are writable, word 0 is the constant ID_WORD
    apb_pkg::data_t regs [1:apb_pkg::REGS_PER_SLAVE-1];

    apb_pkg::addr_t                    offset;
    logic [apb_pkg::REG_IDX_WIDTH-1:0] idx;
    logic                              access;
    logic                              bad_off;
    logic                              err;
    logic                              wr_en;

    // byte offset of the request inside this block's window
    assign offset  = bus.paddr - periph_map_pkg::window_start[SLAVE_INDEX];
    assign idx     = offset[apb_pkg::REG_IDX_WIDTH+1:2];
    assign bad_off = (offset >= periph_map_pkg::REG_SPAN);

    assign access  = bus.psel && bus.penable;

    // errors: offset past the last register, or an attempt to write the ID
    assign err     = access && (bad_off || (bus.pwrite && (idx == '0)));
    assign wr_en   = access && bus.pwrite && !err;

    // no wait states, the transfer ends in its first access cycle
    assign bus.pready  = access;
    assign bus.pslverr = err;

    always_comb begin
        bus.prdata = '0;
        if (access && !bad_off) begin
            if (idx == '0) begin
                bus.prdata = ID_WORD;
            end else begin
                bus.prdata = regs[idx];
            end
        end
    end

    // ************************************************************************
    // register storage, written on the edge that closes the access cycle
    // ************************************************************************
    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            for (int k = 1; k < apb_pkg::REGS_PER_SLAVE; k++) begin
                regs[k] <= '0;
            end
        end else if (wr_en) begin
            regs[idx] <= bus.pwdata;
        end
    end

endmodule

// File: apb_resp_mux.sv
// apb_resp_mux
// Returns read data, ready and error of the selected block to the
// requester, and answers unmapped accesses with an error.

`timescale 1ns/1ps

module apb_resp_mux (
    apb_if.monitor          slv [apb_pkg::NB_SLAVE],
    input  logic            miss,
    output apb_pkg::data_t  prdata,
    output logic            pready,
    output logic            pslverr
);

    logic [apb_pkg::NB_SLAVE-1:0] sel;
    logic [apb_pkg::NB_SLAVE-1:0] pen;
    logic [apb_pkg::NB_SLAVE-1:0] rdy;
    logic [apb_pkg::NB_SLAVE-1:0] serr;
    apb_pkg::data_t               rdata [apb_pkg::NB_SLAVE];

    // interface arrays only take constant indices, so flatten them first
    genvar g;
    generate
        for (g = 0; g < apb_pkg::NB_SLAVE; g++) begin : g_flat
            assign sel[g]   = slv[g].psel;
            assign pen[g]   = slv[g].penable;
            assign rdy[g]   = slv[g].pready;
            assign serr[g]  = slv[g].pslverr;
            assign rdata[g] = slv[g].prdata;
        end
    endgenerate

    always_comb begin
        prdata  = '0;
        pready  = 1'b0;
        pslverr = 1'b0;
        if (miss && (|pen)) begin
            // nobody owns the address, so complete the access with an error
            pready  = 1'b1;
            pslverr = 1'b1;
        end else begin
            for (int i = 0; i < apb_pkg::NB_SLAVE; i++) begin
                if (sel[i]) begin
                    prdata  = rdata[i];
                    pready  = rdy[i];
                    pslverr = serr[i];
                end
            end
        end
    end

endmodule

// File: periph_bus.sv
// periph_bus
// APB peripheral bus top: one requester port, an address decoder, four
// register blocks and the response multiplexer.

`timescale 1ns/1ps

module periph_bus (
    input  logic            clk_i,
    input  logic            arst_n,
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  apb_pkg::addr_t  paddr,
    input  apb_pkg::data_t  pwdata,
    output apb_pkg::data_t  prdata,
    output logic            pready,
    output logic            pslverr
);

    logic miss;

    // one APB segment per peripheral window
    apb_if s_slaves [apb_pkg::NB_SLAVE] ();

    apb_addr_decode u_decode (
        .psel    ( psel     ),
        .penable ( penable  ),
        .pwrite  ( pwrite   ),
        .paddr   ( paddr    ),
        .pwdata  ( pwdata   ),
        .slv     ( s_slaves ),
        .miss    ( miss     )
    );

    // ************************************************************************
    // peripheral register blocks
    // ************************************************************************
    genvar i;
    generate
        for (i = 0; i < apb_pkg::NB_SLAVE; i++) begin : g_periph
            apb_reg_slave #(
                .SLAVE_INDEX ( i )
            ) u_reg_slave (
                .clk_i  ( clk_i       ),
                .arst_n ( arst_n      ),
                .bus    ( s_slaves[i] )
            );
        end
    endgenerate

    apb_resp_mux u_resp_mux (
        .slv     ( s_slaves ),
        .miss    ( miss     ),
        .prdata  ( prdata   ),
        .pready  ( pready   ),
        .pslverr ( pslverr  )
    );

endmodule

// File: periph_bus_sva.sv
// periph_bus_sva
// APB protocol and decode assertions, bound into the peripheral bus top.

`timescale 1ns/1ps

module periph_bus_sva (
    input logic                         clk_i,
    input logic                         arst_n,
    input logic                         psel,
    input logic                         penable,
    input apb_pkg::addr_t               paddr,
    input logic                         pslverr,
    input logic                         miss,
    input logic [apb_pkg::NB_SLAVE-1:0] slv_psel
);

    // penable is only legal inside a selected transfer
    a_penable_psel: assert property (@(posedge clk_i) disable iff (!arst_n)
        penable |-> psel)
        else $error("penable high without psel");

    // windows do not overlap, so the decoder selects one block at most
    a_one_select: assert property (@(posedge clk_i) disable iff (!arst_n)
        $onehot0(slv_psel))
        else $error("more than one block selected");

    a_miss_err: assert property (@(posedge clk_i) disable iff (!arst_n)
        (miss && penable) |-> pslverr)
        else $error("unmapped access completed without pslverr");

    a_addr_stable: assert property (@(posedge clk_i) disable iff (!arst_n)
        (psel && !penable) |=> (penable && $stable(paddr)))
        else $error("paddr changed between setup and access");

endmodule

bind periph_bus periph_bus_sva u_sva (
    .clk_i    ( clk_i   ),
    .arst_n   ( arst_n  ),
    .psel     ( psel    ),
    .penable  ( penable ),
    .paddr    ( paddr   ),
    .pslverr  ( pslverr ),
    .miss     ( miss    ),
    .slv_psel ( {s_slaves[3].psel, s_slaves[2].psel, s_slaves[1].psel, s_slaves[0].psel} )
);

// File: periph_map_pkg.sv
// periph_map_pkg
// Fixed address map of the four peripheral windows and the constants that
// identify each register block.

package periph_map_pkg;

    // first byte of the peripheral region and the size of one window
    localparam apb_pkg::addr_t PERIPH_BASE = 32'h1A10_0000;
    localparam apb_pkg::addr_t WINDOW_SIZE = 32'h0000_1000;

    // bytes occupied by the registers at the bottom of each window
    localparam apb_pkg::addr_t REG_SPAN = apb_pkg::REGS_PER_SLAVE * 4;

    // block i answers word 0 with ID_BASE + i
    localparam apb_pkg::data_t ID_BASE = 32'h5045_0000;

    typedef apb_pkg::addr_t addr_arr_t [apb_pkg::NB_SLAVE];

    // windows are packed back to back from PERIPH_BASE upward
    function automatic addr_arr_t calc_window_start();
        addr_arr_t starts;
        for (int i = 0; i < apb_pkg::NB_SLAVE; i++) begin
            starts[i] = PERIPH_BASE + apb_pkg::addr_t'(i) * WINDOW_SIZE;
        end
        return starts;
    endfunction

    function automatic addr_arr_t calc_window_end();
        addr_arr_t ends;
        for (int i = 0; i < apb_pkg::NB_SLAVE; i++) begin
            ends[i] = PERIPH_BASE + apb_pkg::addr_t'(i + 1) * WINDOW_SIZE - 1;
        end
        return ends;
    endfunction

    localparam addr_arr_t window_start = calc_window_start();
    localparam addr_arr_t window_end   = calc_window_end();

endpackage

// File: tb_periph_bus.sv
// tb_periph_bus
// Directed testbench for the APB peripheral bus. Drives APB transfers on the
// top-level ports and checks data and error responses against a reference map.

`timescale 1ns/1ps

module tb_periph_bus;

    localparam int unsigned TIMEOUT_CYCLES = 20;

    logic           clk_i;
    logic           arst_n;
    logic           psel;
    logic           penable;
    logic           pwrite;
    apb_pkg::addr_t paddr;
    apb_pkg::data_t pwdata;
    apb_pkg::data_t prdata;
    logic           pready;
    logic           pslverr;

    // expected contents of every block including word 0
    apb_pkg::data_t exp_mem [apb_pkg::NB_SLAVE][apb_pkg::REGS_PER_SLAVE];

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    periph_bus u_dut (
        .clk_i   ( clk_i   ),
        .arst_n  ( arst_n  ),
        .psel    ( psel    ),
        .penable ( penable ),
        .pwrite  ( pwrite  ),
        .paddr   ( paddr   ),
        .pwdata  ( pwdata  ),
        .prdata  ( prdata  ),
        .pready  ( pready  ),
        .pslverr ( pslverr )
    );

    always #5 clk_i = ~clk_i;

    // ************************************************************************
    // helpers
    // ************************************************************************

    // Fibonacci LFSR with taps 32, 22, 2 and 1 that yields one bit per step
    function automatic logic lfsr_next_bit();
        logic fb;
        logic out;
        out        = lfsr_state[31];
        fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return out;
    endfunction

    function automatic apb_pkg::data_t rand_word();
        apb_pkg::data_t w;
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_next_bit()};
        end
        return w;
    endfunction

    function automatic apb_pkg::addr_t reg_addr(input int blk, input int word);
        return periph_map_pkg::PERIPH_BASE + apb_pkg::addr_t'(blk) * periph_map_pkg::WINDOW_SIZE
               + apb_pkg::addr_t'(4 * word);
    endfunction

    task automatic compare_word(input string name, input logic [31:0] exp,
                                input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("[ERROR] %0t ns %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    // one APB transfer with a setup cycle, an access cycle and a wait for pready
    task automatic apb_transfer(input logic wr, input apb_pkg::addr_t addr,
                                input apb_pkg::data_t wdata,
                                output apb_pkg::data_t rdata, output logic err);
        int waited;
        waited = 0;
        @(posedge clk_i);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_i);
        penable <= 1'b1;
        @(negedge clk_i);
        while (!pready && waited < TIMEOUT_CYCLES) begin
            @(negedge clk_i);
            waited++;
        end
        if (!pready) begin
            $display("transfer to %h never saw pready within %0d cycles", addr, TIMEOUT_CYCLES);
            errors++;
        end else if (waited != 0) begin
            $display("transfer to %h took %0d wait states, none expected", addr, waited);
            errors++;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_i);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_write(input apb_pkg::addr_t addr, input apb_pkg::data_t data,
                             output logic err);
        apb_pkg::data_t unused;
        apb_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input apb_pkg::addr_t addr, output apb_pkg::data_t data,
                            output logic err);
        apb_transfer(1'b0, addr, '0, data, err);
    endtask

    // read one word and compare it with the reference map
    task automatic read_expect(input int blk, input int word);
        apb_pkg::data_t d;
        logic           e;
        apb_read(reg_addr(blk, word), d, e);
        compare_word($sformatf("prdata blk%0d word%0d", blk, word), exp_mem[blk][word], d);
        compare_word("pslverr", 32'd0, 32'(e));
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %-16s : %0d errors", name, errors - err_before);
    endtask

    // ************************************************************************
    // directed tests
    // ************************************************************************
    task automatic test_reset_state();
        int e0;
        e0 = errors;
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            for (int w = 0; w < apb_pkg::REGS_PER_SLAVE; w++) begin
                read_expect(b, w);
            end
        end
        report_test("reset_state", e0);
    endtask

    task automatic test_read_back();
        int   e0;
        logic e;
        e0 = errors;
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            for (int w = 1; w < apb_pkg::REGS_PER_SLAVE; w++) begin
                exp_mem[b][w] = rand_word();
                apb_write(reg_addr(b, w), exp_mem[b][w], e);
                compare_word("pslverr", 32'd0, 32'(e));
            end
        end
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            for (int w = 1; w < apb_pkg::REGS_PER_SLAVE; w++) begin
                read_expect(b, w);
            end
        end
        report_test("read_back", e0);
    endtask

    task automatic test_isolation();
        int   e0;
        logic e;
        e0 = errors;
        exp_mem[2][2] = rand_word();
        apb_write(reg_addr(2, 2), exp_mem[2][2], e);
        compare_word("pslverr", 32'd0, 32'(e));
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            read_expect(b, 2);
        end
        report_test("isolation", e0);
    endtask

    task automatic test_id_read_only();
        int   e0;
        logic e;
        e0 = errors;
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            apb_write(reg_addr(b, 0), rand_word(), e);
            compare_word("pslverr", 32'd1, 32'(e));
            read_expect(b, 0);
        end
        report_test("id_read_only", e0);
    endtask

    task automatic test_bad_offset();
        int             e0;
        logic           e;
        apb_pkg::data_t d;
        e0 = errors;
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            // byte offset 20 has the same low address bits as word 1
            apb_write(reg_addr(b, 5), rand_word(), e);
            compare_word("pslverr", 32'd1, 32'(e));
            apb_read(reg_addr(b, 1023), d, e);
            compare_word("pslverr", 32'd1, 32'(e));
            compare_word("prdata", 32'd0, d);
            for (int w = 1; w < apb_pkg::REGS_PER_SLAVE; w++) begin
                read_expect(b, w);
            end
        end
        report_test("bad_offset", e0);
    endtask

    task automatic test_unmapped();
        int             e0;
        logic           e;
        apb_pkg::data_t d;
        apb_pkg::addr_t bad [2];
        e0     = errors;
        bad[0] = periph_map_pkg::PERIPH_BASE - 4;
        bad[1] = periph_map_pkg::PERIPH_BASE
                 + apb_pkg::addr_t'(apb_pkg::NB_SLAVE) * periph_map_pkg::WINDOW_SIZE;
        for (int i = 0; i < 2; i++) begin
            apb_write(bad[i], rand_word(), e);
            compare_word("pslverr", 32'd1, 32'(e));
            apb_read(bad[i], d, e);
            compare_word("pslverr", 32'd1, 32'(e));
            compare_word("prdata", 32'd0, d);
        end
        report_test("unmapped", e0);
    endtask

    initial begin
        clk_i      = 1'b0;
        arst_n     = 1'b0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = '0;
        pwdata     = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 32'hf6c8_ed00;
        for (int b = 0; b < apb_pkg::NB_SLAVE; b++) begin
            exp_mem[b][0] = periph_map_pkg::ID_BASE + apb_pkg::data_t'(b);
            for (int w = 1; w < apb_pkg::REGS_PER_SLAVE; w++) begin
                exp_mem[b][w] = '0;
            end
        end
        repeat (10) @(posedge clk_i);
        arst_n <= 1'b1;

        test_reset_state();
        test_read_back();
        test_isolation();
        test_id_read_only();
        test_bad_offset();
        test_unmapped();

        $display("tests run: 6, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
apb_pkg.sv
periph_map_pkg.sv
apb_if.sv
apb_addr_decode.sv
apb_reg_slave.sv
apb_resp_mux.sv
periph_bus.sv
periph_bus_sva.sv
tb_periph_bus.sv
